// File: common/rv32_config.svh
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

`define RV_XLEN     32
`define RV_NR_REGS  32
`define RV_PC_RESET 32'h20400000

`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`define RV_F3_ADD  3'b000 // also JALR, BEQ
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111
`define RV_F3_WORD 3'b010 // LW and SW

`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000 // SUB, SRA, SRAI

`endif

// File: common/rv32_pkg.sv
`default_nettype none

`include "rv32_config.svh"

package rv32_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] br_cond_t; // funct3 of a branch

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        OPERANDS,
        EXECUTE,
        ACCESS,
        WRITEBACK
    } stage_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA
    } alu_op_t;

endpackage

`default_nettype wire

// File: core/rv32_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_alu (
    input  wire               i_clk,
    input  wire               i_rst,
    input  wire               i_exec,
    input  rv32_pkg::alu_op_t i_op,
    input  rv32_pkg::word_t   i_a,
    input  rv32_pkg::word_t   i_b,
    input  rv32_pkg::word_t   i_cmp_a,
    input  rv32_pkg::word_t   i_cmp_b,
    output rv32_pkg::word_t   o_result,
    output logic              o_eq,
    output logic              o_lt,
    output logic              o_ltu
);

    wire [4:0] shamt = i_b[4:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_result <= '0;
            o_eq     <= 1'b0;
            o_lt     <= 1'b0;
            o_ltu    <= 1'b0;
        end else if (i_exec) begin
            case (i_op)
                rv32_pkg::SUB:  o_result <= i_a - i_b;
                rv32_pkg::SLT:  o_result <= rv32_pkg::word_t'($signed(i_a) < $signed(i_b));
                rv32_pkg::SLTU: o_result <= rv32_pkg::word_t'(i_a < i_b);
                rv32_pkg::XOR:  o_result <= i_a ^ i_b;
                rv32_pkg::OR:   o_result <= i_a | i_b;
                rv32_pkg::AND:  o_result <= i_a & i_b;
                rv32_pkg::SLL:  o_result <= i_a << shamt;
                rv32_pkg::SRL:  o_result <= i_a >> shamt;
                rv32_pkg::SRA:  o_result <= $signed(i_a) >>> shamt;
                default:        o_result <= i_a + i_b;
            endcase
            // branch flags come from the register values, not the operands
            o_eq  <= i_cmp_a == i_cmp_b;
            o_lt  <= $signed(i_cmp_a) < $signed(i_cmp_b);
            o_ltu <= i_cmp_a < i_cmp_b;
        end
    end

endmodule

`default_nettype wire

// File: core/rv32_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_config.svh"

module rv32_decoder (
    input  wire                i_clk,
    input  wire                i_rst,
    input  wire                i_load,
    input  rv32_pkg::word_t    i_instr,
    output rv32_pkg::reg_idx_t o_rs1,
    output rv32_pkg::reg_idx_t o_rs2,
    output rv32_pkg::reg_idx_t o_rd,
    output rv32_pkg::word_t    o_imm,
    output rv32_pkg::alu_op_t  o_alu_op,
    output rv32_pkg::br_cond_t o_br_cond,
    output logic               o_is_lui,
    output logic               o_is_auipc,
    output logic               o_is_jal,
    output logic               o_is_jalr,
    output logic               o_is_branch,
    output logic               o_is_load,
    output logic               o_is_store,
    output logic               o_is_op_imm,
    output logic               o_is_op_reg,
    output logic               o_is_shift_imm
);

    wire [6:0] opcode = i_instr[6:0];
    wire [2:0] funct3 = i_instr[14:12];
    wire [6:0] funct7 = i_instr[31:25];

    logic              is_shift_f3;
    logic              f7_ok;
    rv32_pkg::word_t   imm;
    rv32_pkg::alu_op_t alu_op;

    assign is_shift_f3 = (funct3 == `RV_F3_SLL) || (funct3 == `RV_F3_SR);
    // SUB and SRA/SRAI are the only users of the alternate funct7
    assign f7_ok = (funct7 == `RV_F7_BASE) ||
                   (funct7 == `RV_F7_ALT && (funct3 == `RV_F3_SR ||
                   (funct3 == `RV_F3_ADD && opcode == `RV_OP_REG)));

    always_comb begin
        case (opcode)
            `RV_OP_STORE:  imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            `RV_OP_BRANCH: imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                  i_instr[11:8], 1'b0};
            `RV_OP_LUI,
            `RV_OP_AUIPC:  imm = {i_instr[31:12], 12'h000};
            `RV_OP_JAL:    imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                  i_instr[30:21], 1'b0};
            default:       imm = {{20{i_instr[31]}}, i_instr[31:20]}; // I-type
        endcase
    end

    always_comb begin
        case (funct3)
            `RV_F3_ADD:  alu_op = (opcode == `RV_OP_REG && funct7 == `RV_F7_ALT) ?
                                  rv32_pkg::SUB : rv32_pkg::ADD;
            `RV_F3_SLL:  alu_op = rv32_pkg::SLL;
            `RV_F3_SLT:  alu_op = rv32_pkg::SLT;
            `RV_F3_SLTU: alu_op = rv32_pkg::SLTU;
            `RV_F3_XOR:  alu_op = rv32_pkg::XOR;
            `RV_F3_SR:   alu_op = (funct7 == `RV_F7_ALT) ? rv32_pkg::SRA : rv32_pkg::SRL;
            `RV_F3_OR:   alu_op = rv32_pkg::OR;
            default:     alu_op = rv32_pkg::AND;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_is_lui       <= 1'b0;
            o_is_auipc     <= 1'b0;
            o_is_jal       <= 1'b0;
            o_is_jalr      <= 1'b0;
            o_is_branch    <= 1'b0;
            o_is_load      <= 1'b0;
            o_is_store     <= 1'b0;
            o_is_op_imm    <= 1'b0;
            o_is_op_reg    <= 1'b0;
            o_is_shift_imm <= 1'b0;
        end else if (i_load) begin
            o_is_lui       <= opcode == `RV_OP_LUI;
            o_is_auipc     <= opcode == `RV_OP_AUIPC;
            o_is_jal       <= opcode == `RV_OP_JAL;
            o_is_jalr      <= opcode == `RV_OP_JALR && funct3 == `RV_F3_ADD;
            o_is_branch    <= opcode == `RV_OP_BRANCH && funct3[2:1] != 2'b01;
            o_is_load      <= opcode == `RV_OP_LOAD && funct3 == `RV_F3_WORD;
            o_is_store     <= opcode == `RV_OP_STORE && funct3 == `RV_F3_WORD;
            o_is_op_imm    <= opcode == `RV_OP_IMM && !is_shift_f3;
            o_is_op_reg    <= opcode == `RV_OP_REG && f7_ok;
            o_is_shift_imm <= opcode == `RV_OP_IMM && is_shift_f3 && f7_ok;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_rs1     <= i_instr[19:15];
            o_rs2     <= i_instr[24:20]; // shamt for immediate shifts
            o_rd      <= i_instr[11:7];
            o_imm     <= imm;
            o_alu_op  <= alu_op;
            o_br_cond <= funct3;
        end
    end

    a_one_class: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0({o_is_lui, o_is_auipc, o_is_jal, o_is_jalr, o_is_branch, o_is_load,
                  o_is_store, o_is_op_imm, o_is_op_reg, o_is_shift_imm}));

endmodule

`default_nettype wire

// File: core/rv32_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_config.svh"

module rv32_regfile (
    input  wire                i_clk,
    input  wire                i_rst,
    input  rv32_pkg::reg_idx_t i_raddr1,
    input  rv32_pkg::reg_idx_t i_raddr2,
    input  wire                i_we,
    input  rv32_pkg::reg_idx_t i_waddr,
    input  rv32_pkg::word_t    i_wdata,
    output rv32_pkg::word_t    o_rdata1,
    output rv32_pkg::word_t    o_rdata2
);

    rv32_pkg::word_t regs [`RV_NR_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin // x0 is never written
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: core/rv32_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_config.svh"

module rv32_sequencer (
    input  wire                i_clk,
    input  wire                i_rst,
    input  rv32_pkg::reg_idx_t i_rs1,
    input  rv32_pkg::reg_idx_t i_rs2,
    input  rv32_pkg::reg_idx_t i_rd,
    input  rv32_pkg::word_t    i_imm,
    input  rv32_pkg::alu_op_t  i_alu_op,
    input  rv32_pkg::br_cond_t i_br_cond,
    input  wire                i_is_lui,
    input  wire                i_is_auipc,
    input  wire                i_is_jal,
    input  wire                i_is_jalr,
    input  wire                i_is_branch,
    input  wire                i_is_load,
    input  wire                i_is_store,
    input  wire                i_is_op_imm,
    input  wire                i_is_op_reg,
    input  wire                i_is_shift_imm,
    input  rv32_pkg::word_t    i_rdata1,
    input  rv32_pkg::word_t    i_rdata2,
    input  rv32_pkg::word_t    i_alu_result,
    input  wire                i_eq,
    input  wire                i_lt,
    input  wire                i_ltu,
    input  wire                i_bus_done,
    input  rv32_pkg::word_t    i_bus_rdata,
    output logic               o_dec_load,
    output rv32_pkg::word_t    o_instr,
    output rv32_pkg::reg_idx_t o_rf_raddr1,
    output rv32_pkg::reg_idx_t o_rf_raddr2,
    output logic               o_rf_we,
    output rv32_pkg::reg_idx_t o_rf_waddr,
    output rv32_pkg::word_t    o_rf_wdata,
    output logic               o_alu_exec,
    output rv32_pkg::alu_op_t  o_alu_op,
    output rv32_pkg::word_t    o_alu_a,
    output rv32_pkg::word_t    o_alu_b,
    output logic               o_bus_req,
    output logic               o_bus_we,
    output rv32_pkg::word_t    o_bus_addr,
    output rv32_pkg::word_t    o_bus_wdata
);

    rv32_pkg::stage_t stage;
    rv32_pkg::word_t  pc;
    rv32_pkg::word_t  next_pc;
    rv32_pkg::word_t  target;
    logic             pending; // load/store issued, waiting for done
    logic             taken;
    logic             is_mem;
    logic             is_jump;

    assign is_mem  = i_is_load | i_is_store;
    assign is_jump = i_is_jal | i_is_jalr;
    assign target  = i_is_jalr ? {i_alu_result[31:1], 1'b0} : i_alu_result;

    always_comb begin
        case (i_br_cond)
            `RV_F3_BEQ:  taken = i_eq;
            `RV_F3_BNE:  taken = !i_eq;
            `RV_F3_BLT:  taken = i_lt;
            `RV_F3_BGE:  taken = !i_lt;
            `RV_F3_BLTU: taken = i_ltu;
            `RV_F3_BGEU: taken = !i_ltu;
            default:     taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage   <= rv32_pkg::FETCH;
            pc      <= `RV_PC_RESET;
            next_pc <= `RV_PC_RESET;
            pending <= 1'b0;
        end else begin
            case (stage)
                rv32_pkg::FETCH: begin
                    next_pc <= pc + 32'd4;
                    stage   <= rv32_pkg::DECODE;
                end
                rv32_pkg::DECODE: if (i_bus_done) stage <= rv32_pkg::OPERANDS;
                rv32_pkg::OPERANDS: stage <= rv32_pkg::EXECUTE;
                rv32_pkg::EXECUTE:  stage <= rv32_pkg::ACCESS;
                rv32_pkg::ACCESS: begin
                    if (!is_mem) begin
                        stage <= rv32_pkg::WRITEBACK;
                    end else if (o_bus_req) begin
                        pending <= 1'b1;
                    end else if (i_bus_done) begin
                        pending <= 1'b0;
                        stage   <= rv32_pkg::WRITEBACK;
                    end
                end
                rv32_pkg::WRITEBACK: begin
                    pc    <= (is_jump || (i_is_branch && taken)) ? target : next_pc;
                    stage <= rv32_pkg::FETCH;
                end
                default: stage <= rv32_pkg::FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == rv32_pkg::OPERANDS) begin
            o_alu_a <= (i_is_auipc || i_is_jal || i_is_branch) ? pc : i_rdata1;
            if (i_is_shift_imm) begin
                o_alu_b <= {27'd0, i_rs2};
            end else if (i_is_op_reg) begin
                o_alu_b <= i_rdata2;
            end else begin
                o_alu_b <= i_imm;
            end
            // addresses and link targets always add
            o_alu_op <= (i_is_op_imm || i_is_op_reg || i_is_shift_imm) ? i_alu_op
                                                                       : rv32_pkg::ADD;
        end
    end

    assign o_dec_load  = (stage == rv32_pkg::DECODE) && i_bus_done;
    assign o_instr     = i_bus_rdata;
    assign o_rf_raddr1 = i_rs1;
    assign o_rf_raddr2 = i_rs2;
    assign o_alu_exec  = stage == rv32_pkg::EXECUTE;

    assign o_bus_req   = (stage == rv32_pkg::FETCH) ||
                         (stage == rv32_pkg::ACCESS && is_mem && !pending);
    assign o_bus_we    = (stage == rv32_pkg::ACCESS) && i_is_store;
    assign o_bus_addr  = (stage == rv32_pkg::FETCH) ? pc : i_alu_result;
    assign o_bus_wdata = i_rdata2;

    assign o_rf_we    = (stage == rv32_pkg::WRITEBACK) &&
                        (i_is_lui || i_is_auipc || is_jump || i_is_load ||
                         i_is_op_imm || i_is_op_reg || i_is_shift_imm);
    assign o_rf_waddr = i_rd;
    assign o_rf_wdata = i_is_lui  ? i_imm :
                        is_jump   ? next_pc :
                        i_is_load ? i_bus_rdata : i_alu_result;

    a_req_stage: assert property (@(posedge i_clk) disable iff (i_rst)
        o_bus_req |=> stage == rv32_pkg::DECODE || (stage == rv32_pkg::ACCESS && pending));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv32_core.f --top-module tb_rv32_core -o sim_rv32

output="$(./obj_dir/sim_rv32)"
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: rv32_core.f
+incdir+common
common/rv32_pkg.sv
core/rv32_decoder.sv
core/rv32_regfile.sv
core/rv32_alu.sv
core/rv32_sequencer.sv
src/wb_master.sv
src/rv32_core.sv
testbench/tb_wb_memory.sv
testbench/tb_rv32_core.sv

// File: src/rv32_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_ack,
    input  wire             i_stall,
    input  rv32_pkg::word_t i_data,
    output wire             o_we,
    output wire             o_stb,
    output wire             o_cyc,
    output rv32_pkg::word_t o_addr,
    output rv32_pkg::word_t o_data
);

    rv32_pkg::reg_idx_t rs1, rs2, rd, raddr1, raddr2, waddr;
    rv32_pkg::word_t    imm, instr, rdata1, rdata2, wdata, alu_result, alu_a, alu_b;
    rv32_pkg::word_t    bus_addr, bus_wdata, bus_rdata;
    rv32_pkg::alu_op_t  dec_alu_op, alu_op;
    rv32_pkg::br_cond_t br_cond;
    logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic is_load, is_store, is_op_imm, is_op_reg, is_shift_imm;
    logic dec_load, rf_we, alu_exec, eq, lt, ltu, bus_req, bus_we, bus_done;

    rv32_sequencer u_seq (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd), .i_imm(imm),
        .i_alu_op(dec_alu_op), .i_br_cond(br_cond),
        .i_is_lui(is_lui), .i_is_auipc(is_auipc), .i_is_jal(is_jal),
        .i_is_jalr(is_jalr), .i_is_branch(is_branch), .i_is_load(is_load),
        .i_is_store(is_store), .i_is_op_imm(is_op_imm), .i_is_op_reg(is_op_reg),
        .i_is_shift_imm(is_shift_imm),
        .i_rdata1(rdata1), .i_rdata2(rdata2), .i_alu_result(alu_result),
        .i_eq(eq), .i_lt(lt), .i_ltu(ltu),
        .i_bus_done(bus_done), .i_bus_rdata(bus_rdata),
        .o_dec_load(dec_load), .o_instr(instr),
        .o_rf_raddr1(raddr1), .o_rf_raddr2(raddr2),
        .o_rf_we(rf_we), .o_rf_waddr(waddr), .o_rf_wdata(wdata),
        .o_alu_exec(alu_exec), .o_alu_op(alu_op), .o_alu_a(alu_a), .o_alu_b(alu_b),
        .o_bus_req(bus_req), .o_bus_we(bus_we), .o_bus_addr(bus_addr),
        .o_bus_wdata(bus_wdata)
    );

    rv32_decoder u_dec (
        .i_clk(i_clk), .i_rst(i_rst), .i_load(dec_load), .i_instr(instr),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(dec_alu_op), .o_br_cond(br_cond),
        .o_is_lui(is_lui), .o_is_auipc(is_auipc), .o_is_jal(is_jal),
        .o_is_jalr(is_jalr), .o_is_branch(is_branch), .o_is_load(is_load),
        .o_is_store(is_store), .o_is_op_imm(is_op_imm), .o_is_op_reg(is_op_reg),
        .o_is_shift_imm(is_shift_imm)
    );

    rv32_regfile u_rf (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_raddr1(raddr1), .i_raddr2(raddr2),
        .i_we(rf_we), .i_waddr(waddr), .i_wdata(wdata),
        .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    rv32_alu u_alu (
        .i_clk(i_clk), .i_rst(i_rst), .i_exec(alu_exec), .i_op(alu_op),
        .i_a(alu_a), .i_b(alu_b), .i_cmp_a(rdata1), .i_cmp_b(rdata2),
        .o_result(alu_result), .o_eq(eq), .o_lt(lt), .o_ltu(ltu)
    );

    wb_master u_bus (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_req(bus_req), .i_we(bus_we), .i_addr(bus_addr), .i_wdata(bus_wdata),
        .i_ack(i_ack), .i_stall(i_stall), .i_data(i_data),
        .o_cyc(o_cyc), .o_stb(o_stb), .o_we(o_we), .o_addr(o_addr), .o_data(o_data),
        .o_done(bus_done), .o_rdata(bus_rdata)
    );

endmodule

`default_nettype wire

// File: src/wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_master (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_req,
    input  wire             i_we,
    input  rv32_pkg::word_t i_addr,
    input  rv32_pkg::word_t i_wdata,
    input  wire             i_ack,
    input  wire             i_stall,
    input  rv32_pkg::word_t i_data,
    output logic            o_cyc,
    output logic            o_stb,
    output logic            o_we,
    output rv32_pkg::word_t o_addr,
    output rv32_pkg::word_t o_data,
    output logic            o_done,
    output rv32_pkg::word_t o_rdata
);

    typedef enum logic {IDLE, BUSY} state_t;

    state_t state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= IDLE;
            o_cyc  <= 1'b0;
            o_stb  <= 1'b0;
            o_we   <= 1'b0;
            o_done <= 1'b0;
            o_addr <= '0;
        end else begin
            o_done <= 1'b0;
            case (state)
                IDLE: if (i_req) begin
                    state  <= BUSY;
                    o_cyc  <= 1'b1;
                    o_stb  <= 1'b1;
                    o_we   <= i_we;
                    o_addr <= i_addr;
                end
                default: begin
                    if (o_stb && !i_stall) o_stb <= 1'b0; // slave took the request
                    if (i_ack) begin
                        state  <= IDLE;
                        o_cyc  <= 1'b0;
                        o_we   <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_req) o_data <= i_wdata;
        if (state == BUSY && i_ack) o_rdata <= i_data;
    end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) o_stb |-> o_cyc);
    a_req_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_req |-> state == IDLE);

endmodule

`default_nettype wire

// File: testbench/tb_rv32_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv32_config.svh"

module tb_rv32_core;

    localparam int CYCLE_LIMIT = 20000; // about four times the longest run of all tests
    localparam logic [31:0] DATA_BASE = 32'h20402000;

    logic        clk;
    logic        rst;
    wire         ack, stall, cyc, stb, we;
    wire  [31:0] rdata, addr, wdata;
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];
    logic [31:0] rd_addr [$];
    logic [31:0] seed = 32'hf2a61615;
    logic        cyc_q = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          off = 0;

    rv32_core DUT (
        .i_clk(clk), .i_rst(rst), .i_ack(ack), .i_stall(stall), .i_data(rdata),
        .o_we(we), .o_stb(stb), .o_cyc(cyc), .o_addr(addr), .o_data(wdata)
    );

    tb_wb_memory u_mem (
        .i_clk(clk), .i_rst(rst), .i_cyc(cyc), .i_stb(stb), .i_we(we),
        .i_addr(addr), .i_data(wdata), .o_ack(ack), .o_stall(stall), .o_data(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the core did not finish the programs within %0d cycles",
                     CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (cyc && we && ack) begin
            wr_addr.push_back(addr);
            wr_data.push_back(wdata);
        end
        if (cyc && !cyc_q && !we) rd_addr.push_back(addr); // start of a read cycle
        cyc_q <= cyc;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_next(seed);
        r = seed;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {f7, rs2, rs1, f3, 5'd3, `RV_OP_REG}; // result always in x3
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // RV32I result rule for OP and OP-IMM
    function automatic logic [31:0] rv_op(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] pc_now();
        return `RV_PC_RESET + 32'(4 * prog.size());
    endfunction

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        prog.push_back({hi[19:0], rd, `RV_OP_LUI});
        prog.push_back(enc_i(v, rd, `RV_F3_ADD, rd, `RV_OP_IMM));
    endtask

    task automatic expect_store(input logic [4:0] rs2, input logic [31:0] val);
        logic [31:0] o;
        o = 32'(off);
        prog.push_back({o[11:5], rs2, 5'd10, `RV_F3_WORD, o[4:0], `RV_OP_STORE});
        exp_addr.push_back(DATA_BASE + o);
        exp_data.push_back(val);
        off += 4;
    endtask

    task automatic begin_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        off = 0;
        load_const(5'd10, DATA_BASE); // x10 is the store base
    endtask

    task automatic run_program(input string name);
        prog.push_back(enc_j(32'd0, 5'd0)); // park on a jump to itself
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < 4096; i++) u_mem.mem[i] = '0;
        foreach (prog[i]) u_mem.mem[i] = prog[i];
        repeat (2) begin
            @(negedge clk);
            check({name, " bus idle in reset"}, 32'd0, {29'd0, cyc, stb, we});
        end
        wr_addr.delete();
        wr_data.delete();
        rd_addr.delete();
        rst = 1'b0;
        while (wr_data.size() < exp_data.size()) @(posedge clk);
        foreach (exp_data[i]) begin
            check({name, " store address"}, exp_addr[i], wr_addr[i]);
            check({name, " store data"}, exp_data[i], wr_data[i]);
        end
    endtask

    task automatic test_reset_fetch();
        begin_program();
        run_program("reset_fetch");
        while (rd_addr.size() < 3) @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            check("reset_fetch address", `RV_PC_RESET + 32'(4 * i), rd_addr[i]);
        end
    endtask

    task automatic test_alu();
        logic [31:0] a, b, imm;
        logic [2:0]  f3i [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        begin_program();
        for (int round = 0; round < 2; round++) begin
            next_rand(a);
            next_rand(b);
            load_const(5'd1, a);
            load_const(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                prog.push_back(enc_r(`RV_F7_BASE, 5'd2, 5'd1, 3'(f)));
                expect_store(5'd3, rv_op(3'(f), 1'b0, a, b));
            end
            prog.push_back(enc_r(`RV_F7_ALT, 5'd2, 5'd1, `RV_F3_ADD));
            expect_store(5'd3, rv_op(3'd0, 1'b1, a, b));
            prog.push_back(enc_r(`RV_F7_ALT, 5'd2, 5'd1, `RV_F3_SR));
            expect_store(5'd3, rv_op(3'd5, 1'b1, a, b));
            next_rand(imm);
            imm = {{20{imm[11]}}, imm[11:0]};
            foreach (f3i[i]) begin
                prog.push_back(enc_i(imm, 5'd1, f3i[i], 5'd3, `RV_OP_IMM));
                expect_store(5'd3, rv_op(f3i[i], 1'b0, a, imm));
            end
            prog.push_back(enc_i({27'd0, imm[4:0]}, 5'd1, `RV_F3_SLL, 5'd3, `RV_OP_IMM));
            expect_store(5'd3, rv_op(3'd1, 1'b0, a, imm));
            prog.push_back(enc_i({27'd0, imm[4:0]}, 5'd1, `RV_F3_SR, 5'd3, `RV_OP_IMM));
            expect_store(5'd3, rv_op(3'd5, 1'b0, a, imm));
            prog.push_back(enc_i({20'd0, 12'h400 | imm[4:0]}, 5'd1, `RV_F3_SR, 5'd3,
                                 `RV_OP_IMM));
            expect_store(5'd3, rv_op(3'd5, 1'b1, a, imm));
        end
        run_program("alu");
    endtask

    task automatic test_x0();
        begin_program();
        prog.push_back(enc_i(32'd123, 5'd0, `RV_F3_ADD, 5'd0, `RV_OP_IMM));
        prog.push_back(enc_i(32'd7, 5'd10, `RV_F3_ADD, 5'd0, `RV_OP_IMM));
        expect_store(5'd0, 32'd0);
        run_program("x0_zero");
    endtask

    task automatic test_control();
        logic [31:0] pa [3] = '{32'd5, 32'hfffffffd, 32'd5};
        logic [31:0] pb [3] = '{32'd5, 32'd5, 32'hfffffffd};
        logic [2:0]  conds [6] = '{`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT, `RV_F3_BGE,
                                   `RV_F3_BLTU, `RV_F3_BGEU};
        logic [31:0] jpc;
        begin_program();
        foreach (pa[p]) begin
            load_const(5'd1, pa[p]);
            load_const(5'd2, pb[p]);
            foreach (conds[c]) begin
                prog.push_back(enc_i(32'd1, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
                prog.push_back(enc_b(32'd8, conds[c]));
                prog.push_back(enc_i(32'd2, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
                expect_store(5'd5, branch_taken(conds[c], pa[p], pb[p]) ? 32'd1 : 32'd2);
            end
        end
        prog.push_back(enc_i(32'd1, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
        jpc = pc_now();
        prog.push_back(enc_j(32'd8, 5'd6));
        prog.push_back(enc_i(32'd2, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
        expect_store(5'd5, 32'd1);
        expect_store(5'd6, jpc + 32'd4);
        jpc = pc_now(); // AUIPC x7 sets the JALR base
        prog.push_back({20'd0, 5'd7, `RV_OP_AUIPC});
        prog.push_back(enc_i(32'd17, 5'd7, `RV_F3_ADD, 5'd8, `RV_OP_JALR)); // odd target
        prog.push_back(enc_i(32'd3, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
        prog.push_back(enc_i(32'd3, 5'd0, `RV_F3_ADD, 5'd5, `RV_OP_IMM));
        prog.push_back({20'd0, 5'd9, `RV_OP_AUIPC}); // x9 gets the landing PC
        expect_store(5'd9, jpc + 32'd16);
        expect_store(5'd5, 32'd1);
        expect_store(5'd8, jpc + 32'd8);
        run_program("control");
    endtask

    task automatic test_load();
        logic [31:0] v, o;
        begin_program();
        for (int k = 0; k < 4; k++) begin
            next_rand(v);
            load_const(5'd1, v);
            o = 32'(off);
            expect_store(5'd1, v);
            prog.push_back(enc_i(o, 5'd10, `RV_F3_WORD, 5'd2, `RV_OP_LOAD));
            expect_store(5'd2, v);
        end
        run_program("load_store");
    endtask

    initial begin
        rst = 1'b1;
        test_reset_fetch();
        test_alu();
        test_x0();
        test_control();
        test_load();
        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory (
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire         i_cyc,
    input  wire         i_stb,
    input  wire         i_we,
    input  wire  [31:0] i_addr,
    input  wire  [31:0] i_data,
    output logic        o_ack,
    output logic        o_stall,
    output logic [31:0] o_data
);

    logic [31:0] mem [4096]; // 16 KiB window, upper address bits ignored
    logic [31:0] seed = 32'hf2a61615;
    logic        rst_q = 1'b1;
    logic        pend = 1'b0; // request accepted, ack still to come
    int          stall_left = 0;
    int          ack_left = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_delay(output int d);
        seed = lcg_next(seed);
        d = int'(seed[17:16]); // 0 to 3 cycles
    endtask

    initial begin
        o_ack   = 1'b0;
        o_stall = 1'b0;
        o_data  = '0;
    end

    always @(posedge i_clk) rst_q <= i_rst;

    always @(negedge i_clk) begin
        o_ack = 1'b0;
        if (rst_q) begin
            o_stall = 1'b0;
            pend    = 1'b0;
        end else if (pend) begin
            if (ack_left == 0) begin
                o_ack = 1'b1;
                pend  = 1'b0;
            end else begin
                ack_left--;
            end
        end else if (i_cyc && i_stb) begin
            if (stall_left > 0) begin
                o_stall = 1'b1;
                stall_left--;
            end else begin
                o_stall = 1'b0; // taken at the next rising edge
                pend    = 1'b1;
                draw_delay(ack_left);
                if (i_we) mem[i_addr[13:2]] = i_data;
                else o_data = mem[i_addr[13:2]];
            end
        end else begin
            o_stall = 1'b0;
            draw_delay(stall_left);
        end
    end

endmodule

`default_nettype wire
